/* Bender.yml */
package:
  name: pixel_gen

sources:
  # Packages first, then the interface, the stages and the top level.
  - hw/screenGeomPkg.sv
  - hw/colorPkg.sv
  - hw/pixelStageIf.sv
  - hw/screenRegionDecode.sv
  - hw/pixelColorSelect.sv
  - hw/pixelGen.sv
  - target: simulation
    files:
      - sim/pixelGenTb.sv

/* files.f */
hw/screenGeomPkg.sv
hw/colorPkg.sv
hw/pixelStageIf.sv
hw/screenRegionDecode.sv
hw/pixelColorSelect.sv
hw/pixelGen.sv
sim/pixelGenTb.sv

/* hw/colorPkg.sv */
package colorPkg;

   localparam int channelWidth = 4;

   // 12-bit colour, red in the top nibble.
   typedef struct packed {
      logic [channelWidth-1:0] red;
      logic [channelWidth-1:0] green;
      logic [channelWidth-1:0] blue;
   } rgbT;

   // ------------------------------------------------------------
   // Fixed screen colours.
   // ------------------------------------------------------------
   localparam rgbT rgbBlack = 12'h000;
   localparam rgbT rgbWhite = 12'hfff;  // Clear step.
   localparam rgbT rgbRed = 12'hf00;    // Set step.
   localparam rgbT rgbGreen = 12'h0f0;  // Step being edited.
   localparam rgbT rgbBlue = 12'h00f;   // Playback cursor.

   // ------------------------------------------------------------
   // Palette index for the swatch bands.
   // ------------------------------------------------------------
   typedef enum logic [2:0] {
      palWhite = 3'd0,
      palRed = 3'd1,
      palOrange = 3'd2,
      palYellow = 3'd3,
      palGreen = 3'd4,
      palBlue = 3'd5,
      palCyan = 3'd6,
      palMagenta = 3'd7
   } paletteT;

endpackage

/* hw/pixelColorSelect.sv */
`timescale 1ns/1ps

module pixelColorSelect (
   input logic clk,
   input logic rstN,
   pixelStageIf.color pix,
   output colorPkg::rgbT rgb
);

   colorPkg::rgbT rgbNext;
   colorPkg::rgbT stepColor;
   colorPkg::rgbT swatchColor;

   // ------------------------------------------------------------
   // Palette lookup for the swatch bands.
   // ------------------------------------------------------------
   function automatic colorPkg::rgbT paletteColor(input colorPkg::paletteT idx);
      colorPkg::rgbT color;
      case (idx)
         colorPkg::palWhite: color = 12'hfff;
         colorPkg::palRed: color = 12'hf00;
         colorPkg::palOrange: color = 12'hf80;
         colorPkg::palYellow: color = 12'hff0;
         colorPkg::palGreen: color = 12'h0f0;
         colorPkg::palBlue: color = 12'h00f;
         colorPkg::palCyan: color = 12'h0ff;
         colorPkg::palMagenta: color = 12'hf0f;
         default: color = colorPkg::rgbBlack;
      endcase
      return color;
   endfunction

   assign swatchColor = paletteColor(pix.swatch);

   // Edit highlight wins over the track bit.
   always_comb begin
      if (pix.stepEdit) begin
         stepColor = colorPkg::rgbGreen;
      end else if (pix.stepOn) begin
         stepColor = colorPkg::rgbRed;
      end else begin
         stepColor = colorPkg::rgbWhite;
      end
   end

   // ------------------------------------------------------------
   // Class to colour.
   // ------------------------------------------------------------
   always_comb begin
      case (pix.pixelClass)
         screenGeomPkg::pcCursor: rgbNext = colorPkg::rgbBlue;
         screenGeomPkg::pcStep: rgbNext = stepColor;
         screenGeomPkg::pcSwatch: rgbNext = swatchColor;
         default: rgbNext = colorPkg::rgbBlack;   // Blank and grid.
      endcase
   end

   always_ff @(posedge clk) begin
      if (!rstN) begin
         rgb <= colorPkg::rgbBlack;
      end else begin
         rgb <= rgbNext;
      end
   end

endmodule

/* hw/pixelGen.sv */
`timescale 1ns/1ps

module pixelGen (
   input logic clk,
   input logic rstN,
   input logic [screenGeomPkg::cntWidth-1:0] hCnt,
   input logic [screenGeomPkg::cntWidth-1:0] vCnt,
   input logic valid,
   input logic [screenGeomPkg::stepCount-1:0] track0,
   input logic [screenGeomPkg::stepCount-1:0] track1,
   input logic [screenGeomPkg::stepCount-1:0] track2,
   input logic [screenGeomPkg::laneWidth-1:0] trackChange,
   input logic [screenGeomPkg::stepWidth-1:0] trackSelect,
   input logic [screenGeomPkg::cntWidth-1:0] vgaIter,
   input logic [2:0] colorBottom,
   input logic [2:0] colorTop,
   output logic [colorPkg::channelWidth-1:0] vgaRed,
   output logic [colorPkg::channelWidth-1:0] vgaGreen,
   output logic [colorPkg::channelWidth-1:0] vgaBlue
);

   colorPkg::rgbT rgb;

   pixelStageIf stageBus ();

   // ------------------------------------------------------------
   // Stage 1, coordinates to pixel class.
   // ------------------------------------------------------------
   screenRegionDecode decode (
      .clk(clk),
      .rstN(rstN),
      .hCnt(hCnt),
      .vCnt(vCnt),
      .vgaIter(vgaIter),
      .valid(valid),
      .track0(track0),
      .track1(track1),
      .track2(track2),
      .trackChange(trackChange),
      .trackSelect(trackSelect),
      .colorBottom(colorPkg::paletteT'(colorBottom)),
      .colorTop(colorPkg::paletteT'(colorTop)),
      .pix(stageBus.decode)
   );

   // ------------------------------------------------------------
   // Stage 2, pixel class to colour.
   // ------------------------------------------------------------
   pixelColorSelect colorSel (
      .clk(clk),
      .rstN(rstN),
      .pix(stageBus.color),
      .rgb(rgb)
   );

   assign vgaRed = rgb.red;
   assign vgaGreen = rgb.green;
   assign vgaBlue = rgb.blue;

endmodule

/* hw/pixelStageIf.sv */
`timescale 1ns/1ps

// Decoded pixel between stage 1 and stage 2, one per clock.
interface pixelStageIf;

   screenGeomPkg::pixelClassT pixelClass;
   logic stepOn;                        // Track bit of the cell.
   logic stepEdit;                      // Cell under the edit cursor.
   colorPkg::paletteT swatch;           // Only meaningful for pcSwatch.

   modport decode (
      output pixelClass,
      output stepOn,
      output stepEdit,
      output swatch
   );

   modport color (
      input pixelClass,
      input stepOn,
      input stepEdit,
      input swatch
   );

endinterface

/* hw/screenGeomPkg.sv */
package screenGeomPkg;

   // ------------------------------------------------------------
   // Raster.
   // ------------------------------------------------------------
   localparam int cntWidth = 10;        // Raster counters and cursor column.
   localparam int activeWidth = 640;
   localparam int activeHeight = 480;

   // ------------------------------------------------------------
   // Sequencer grid.
   // ------------------------------------------------------------
   // A cell or band ends in its grid line, so the line sits at the
   // last gridLineWidth pixels of each.
   localparam int cellWidth = 40;
   localparam int gridLineWidth = 2;
   localparam int bandHeight = 96;      // Lanes and swatch bands alike.

   localparam int stepCount = 16;       // Steps per track.
   localparam int laneCount = 3;        // Tracks shown, top lane is track 2.
   localparam int stepWidth = 4;
   localparam int laneWidth = 2;

   // Resolved pixel class handed from decode to colour stage.
   typedef enum logic [2:0] {
      pcBlank,                          // Outside the active area.
      pcGrid,                           // Black separator.
      pcCursor,                         // Playback column.
      pcStep,                           // Step cell, flags pick the colour.
      pcSwatch                          // Palette swatch band.
   } pixelClassT;

endpackage

/* hw/screenRegionDecode.sv */
`timescale 1ns/1ps

module screenRegionDecode (
   input logic clk,
   input logic rstN,
   input logic [screenGeomPkg::cntWidth-1:0] hCnt,
   input logic [screenGeomPkg::cntWidth-1:0] vCnt,
   input logic [screenGeomPkg::cntWidth-1:0] vgaIter,
   input logic valid,
   input logic [screenGeomPkg::stepCount-1:0] track0,
   input logic [screenGeomPkg::stepCount-1:0] track1,
   input logic [screenGeomPkg::stepCount-1:0] track2,
   input logic [screenGeomPkg::laneWidth-1:0] trackChange,
   input logic [screenGeomPkg::stepWidth-1:0] trackSelect,
   input colorPkg::paletteT colorBottom,
   input colorPkg::paletteT colorTop,
   pixelStageIf.decode pix
);

   logic [screenGeomPkg::cntWidth-1:0] band;
   logic [screenGeomPkg::cntWidth-1:0] lineInBand;
   logic [screenGeomPkg::cntWidth-1:0] colOffset;
   logic [screenGeomPkg::stepWidth-1:0] stepIdx;
   logic [screenGeomPkg::laneWidth-1:0] laneIdx;
   logic [screenGeomPkg::stepCount-1:0] laneTrack;
   logic cursorHit;

   screenGeomPkg::pixelClassT classNext;
   logic stepOnNext;
   logic stepEditNext;
   colorPkg::paletteT swatchNext;

   // ------------------------------------------------------------
   // Coordinate split.
   // ------------------------------------------------------------
   assign band = screenGeomPkg::cntWidth'(vCnt / screenGeomPkg::bandHeight);
   assign lineInBand = screenGeomPkg::cntWidth'(vCnt % screenGeomPkg::bandHeight);
   assign colOffset = screenGeomPkg::cntWidth'(hCnt % screenGeomPkg::cellWidth);
   assign stepIdx = screenGeomPkg::stepWidth'(hCnt / screenGeomPkg::cellWidth);
   // Top band shows the highest track.
   assign laneIdx = screenGeomPkg::laneWidth'(screenGeomPkg::laneCount - 1 - band);
   assign cursorHit = (hCnt == vgaIter);

   always_comb begin
      case (laneIdx)
         2'd0: laneTrack = track0;
         2'd1: laneTrack = track1;
         default: laneTrack = track2;
      endcase
   end

   // ------------------------------------------------------------
   // Class resolution, highest precedence first.
   // ------------------------------------------------------------
   always_comb begin
      classNext = screenGeomPkg::pcBlank;
      stepOnNext = 1'b0;
      stepEditNext = 1'b0;
      swatchNext = colorPkg::palWhite;
      if (!valid || vCnt >= screenGeomPkg::activeHeight) begin
         classNext = screenGeomPkg::pcBlank;
      end else if (lineInBand >= screenGeomPkg::bandHeight - screenGeomPkg::gridLineWidth) begin
         classNext = cursorHit ? screenGeomPkg::pcCursor : screenGeomPkg::pcGrid;
      end else if (band < screenGeomPkg::laneCount) begin
         if (cursorHit) begin
            classNext = screenGeomPkg::pcCursor;
         end else if (hCnt < screenGeomPkg::activeWidth) begin
            if (colOffset >= screenGeomPkg::cellWidth - screenGeomPkg::gridLineWidth) begin
               classNext = screenGeomPkg::pcGrid;
            end else begin
               classNext = screenGeomPkg::pcStep;
               stepOnNext = laneTrack[stepIdx];
               stepEditNext = (trackChange == laneIdx) && (trackSelect == stepIdx);
            end
         end else begin
            classNext = screenGeomPkg::pcStep;  // Past the grid, plain white.
         end
      end else begin
         classNext = screenGeomPkg::pcSwatch;   // No cursor in swatch bands.
         swatchNext = (band == screenGeomPkg::laneCount) ? colorTop : colorBottom;
      end
   end

   always_ff @(posedge clk) begin
      if (!rstN) begin
         pix.pixelClass <= screenGeomPkg::pcBlank;
         pix.stepOn <= 1'b0;
         pix.stepEdit <= 1'b0;
         pix.swatch <= colorPkg::palWhite;
      end else begin
         pix.pixelClass <= classNext;
         pix.stepOn <= stepOnNext;
         pix.stepEdit <= stepEditNext;
         pix.swatch <= swatchNext;
      end
   end

endmodule

/* sim/pixelGenTb.sv */
`timescale 1ns/1ps

module pixelGenTb;

   localparam int clkPeriod = 8;
   localparam int numRows = 37;
   localparam int numRandom = 2000;

   typedef struct packed {
      logic [9:0] hCnt;
      logic [9:0] vCnt;
      logic valid;
      logic [9:0] vgaIter;
      logic [1:0] trackChange;
      logic [3:0] trackSelect;
      logic [15:0] track0;
      logic [15:0] track1;
      logic [15:0] track2;
      logic [2:0] colorTop;
      logic [2:0] colorBottom;
      logic [11:0] rgb;                 // Expected colour.
   } rowT;

   logic clk = 1'b0;
   logic rstN;
   logic [9:0] hCnt;
   logic [9:0] vCnt;
   logic valid;
   logic [15:0] track0;
   logic [15:0] track1;
   logic [15:0] track2;
   logic [1:0] trackChange;
   logic [3:0] trackSelect;
   logic [9:0] vgaIter;
   logic [2:0] colorBottom;
   logic [2:0] colorTop;
   logic [3:0] vgaRed;
   logic [3:0] vgaGreen;
   logic [3:0] vgaBlue;

   logic [11:0] expQ [$];               // One entry per pixel in flight.

   // Columns are hCnt, vCnt, valid, vgaIter, trackChange, trackSelect,
   // then track0, track1, track2, colorTop, colorBottom and the expected rgb.
   rowT rows [numRows] = '{
      '{10'd20, 10'd200, 1'b1, 10'd1023, 2'd3, 4'd0,
        16'h0011, 16'h0030, 16'h8100, 3'd0, 3'd0, 12'hf00},
      '{10'd220, 10'd200, 1'b1, 10'd1023, 2'd3, 4'd0,
        16'h0011, 16'h0030, 16'h8100, 3'd0, 3'd0, 12'hfff},  // Lane 0 ignores track1.
      '{10'd180, 10'd100, 1'b1, 10'd1023, 2'd3, 4'd0,
        16'h0011, 16'h0030, 16'h8100, 3'd0, 3'd0, 12'hf00},
      '{10'd20, 10'd100, 1'b1, 10'd1023, 2'd3, 4'd0,
        16'h0011, 16'h0030, 16'h8100, 3'd0, 3'd0, 12'hfff},
      '{10'd620, 10'd10, 1'b1, 10'd1023, 2'd3, 4'd0,
        16'h0011, 16'h0030, 16'h8100, 3'd0, 3'd0, 12'hf00},
      '{10'd180, 10'd10, 1'b1, 10'd1023, 2'd3, 4'd0,
        16'h0011, 16'h0030, 16'h8100, 3'd0, 3'd0, 12'hfff},
      // Edit highlight on lane 1, step 4.
      '{10'd170, 10'd150, 1'b1, 10'd1023, 2'd1, 4'd4,
        16'h0011, 16'h0030, 16'h8100, 3'd0, 3'd0, 12'h0f0},
      '{10'd170, 10'd250, 1'b1, 10'd1023, 2'd1, 4'd4,
        16'h0011, 16'h0030, 16'h8100, 3'd0, 3'd0, 12'hf00},
      '{10'd170, 10'd50, 1'b1, 10'd1023, 2'd1, 4'd4,
        16'h0011, 16'h0030, 16'h8100, 3'd0, 3'd0, 12'hfff},
      '{10'd50, 10'd220, 1'b1, 10'd1023, 2'd0, 4'd1,
        16'h0011, 16'h0030, 16'h8100, 3'd0, 3'd0, 12'h0f0},
      // Grid lines and the area right of the grid.
      '{10'd38, 10'd200, 1'b1, 10'd1023, 2'd3, 4'd0,
        16'h0011, 16'h0030, 16'h8100, 3'd0, 3'd0, 12'h000},
      '{10'd639, 10'd100, 1'b1, 10'd1023, 2'd3, 4'd0,
        16'h0011, 16'h0030, 16'h8100, 3'd0, 3'd0, 12'h000},
      '{10'd20, 10'd94, 1'b1, 10'd1023, 2'd3, 4'd0,
        16'h0011, 16'h0030, 16'h8100, 3'd0, 3'd0, 12'h000},
      '{10'd100, 10'd479, 1'b1, 10'd1023, 2'd3, 4'd0,
        16'h0011, 16'h0030, 16'h8100, 3'd0, 3'd0, 12'h000},
      '{10'd700, 10'd50, 1'b1, 10'd1023, 2'd3, 4'd0,
        16'h0011, 16'h0030, 16'h8100, 3'd0, 3'd0, 12'hfff},
      // Cursor on a column grid line, a row grid line, an edited cell.
      '{10'd118, 10'd20, 1'b1, 10'd118, 2'd3, 4'd0,
        16'h0011, 16'h0030, 16'h8100, 3'd0, 3'd0, 12'h00f},
      '{10'd60, 10'd190, 1'b1, 10'd60, 2'd3, 4'd0,
        16'h0011, 16'h0030, 16'h8100, 3'd0, 3'd0, 12'h00f},
      '{10'd170, 10'd150, 1'b1, 10'd170, 2'd1, 4'd4,
        16'h0011, 16'h0030, 16'h8100, 3'd0, 3'd0, 12'h00f},
      '{10'd200, 10'd383, 1'b1, 10'd200, 2'd3, 4'd0,
        16'h0011, 16'h0030, 16'h8100, 3'd0, 3'd0, 12'h00f},
      '{10'd20, 10'd200, 1'b0, 10'd20, 2'd3, 4'd0,
        16'h0011, 16'h0030, 16'h8100, 3'd0, 3'd0, 12'h000},
      '{10'd20, 10'd480, 1'b1, 10'd20, 2'd3, 4'd0,
        16'h0011, 16'h0030, 16'h8100, 3'd0, 3'd0, 12'h000},
      // Top swatch band.
      '{10'd300, 10'd300, 1'b1, 10'd1023, 2'd3, 4'd0,
        16'h0011, 16'h0030, 16'h8100, 3'd0, 3'd7, 12'hfff},
      '{10'd300, 10'd300, 1'b1, 10'd1023, 2'd3, 4'd0,
        16'h0011, 16'h0030, 16'h8100, 3'd1, 3'd6, 12'hf00},
      '{10'd300, 10'd300, 1'b1, 10'd1023, 2'd3, 4'd0,
        16'h0011, 16'h0030, 16'h8100, 3'd2, 3'd5, 12'hf80},
      '{10'd200, 10'd300, 1'b1, 10'd200, 2'd3, 4'd0,
        16'h0011, 16'h0030, 16'h8100, 3'd3, 3'd4, 12'hff0},  // Cursor hidden.
      '{10'd300, 10'd300, 1'b1, 10'd1023, 2'd3, 4'd0,
        16'h0011, 16'h0030, 16'h8100, 3'd4, 3'd3, 12'h0f0},
      '{10'd300, 10'd300, 1'b1, 10'd1023, 2'd3, 4'd0,
        16'h0011, 16'h0030, 16'h8100, 3'd5, 3'd2, 12'h00f},
      '{10'd300, 10'd300, 1'b1, 10'd1023, 2'd3, 4'd0,
        16'h0011, 16'h0030, 16'h8100, 3'd6, 3'd1, 12'h0ff},
      '{10'd300, 10'd300, 1'b1, 10'd1023, 2'd3, 4'd0,
        16'h0011, 16'h0030, 16'h8100, 3'd7, 3'd0, 12'hf0f},
      // Bottom swatch band.
      '{10'd300, 10'd420, 1'b1, 10'd1023, 2'd3, 4'd0,
        16'h0011, 16'h0030, 16'h8100, 3'd7, 3'd0, 12'hfff},
      '{10'd300, 10'd420, 1'b1, 10'd1023, 2'd3, 4'd0,
        16'h0011, 16'h0030, 16'h8100, 3'd6, 3'd1, 12'hf00},
      '{10'd300, 10'd420, 1'b1, 10'd1023, 2'd3, 4'd0,
        16'h0011, 16'h0030, 16'h8100, 3'd5, 3'd2, 12'hf80},
      '{10'd300, 10'd420, 1'b1, 10'd1023, 2'd3, 4'd0,
        16'h0011, 16'h0030, 16'h8100, 3'd4, 3'd3, 12'hff0},
      '{10'd300, 10'd420, 1'b1, 10'd1023, 2'd3, 4'd0,
        16'h0011, 16'h0030, 16'h8100, 3'd3, 3'd4, 12'h0f0},
      '{10'd900, 10'd420, 1'b1, 10'd1023, 2'd3, 4'd0,
        16'h0011, 16'h0030, 16'h8100, 3'd2, 3'd5, 12'h00f},
      '{10'd300, 10'd420, 1'b1, 10'd1023, 2'd3, 4'd0,
        16'h0011, 16'h0030, 16'h8100, 3'd1, 3'd6, 12'h0ff},
      '{10'd300, 10'd420, 1'b1, 10'd1023, 2'd3, 4'd0,
        16'h0011, 16'h0030, 16'h8100, 3'd0, 3'd7, 12'hf0f}
   };

   pixelGen uut (
      .clk(clk),
      .rstN(rstN),
      .hCnt(hCnt),
      .vCnt(vCnt),
      .valid(valid),
      .track0(track0),
      .track1(track1),
      .track2(track2),
      .trackChange(trackChange),
      .trackSelect(trackSelect),
      .vgaIter(vgaIter),
      .colorBottom(colorBottom),
      .colorTop(colorTop),
      .vgaRed(vgaRed),
      .vgaGreen(vgaGreen),
      .vgaBlue(vgaBlue)
   );

   always #(clkPeriod / 2) clk = ~clk;

   // ------------------------------------------------------------
   // Reference model.
   // ------------------------------------------------------------
   function automatic logic [11:0] paletteRgb(input logic [2:0] idx);
      logic [11:0] table8 [8] = '{12'hfff, 12'hf00, 12'hf80, 12'hff0,
                                  12'h0f0, 12'h00f, 12'h0ff, 12'hf0f};
      return table8[idx];
   endfunction

   function automatic logic [11:0] modelPixel(input rowT r);
      int band;
      int line;
      int lane;
      int step;
      logic [15:0] word;
      logic cursor;
      band = r.vCnt / 96;
      line = r.vCnt % 96;
      cursor = (r.hCnt == r.vgaIter);
      if (!r.valid || r.vCnt >= 480) begin
         return 12'h000;
      end
      if (line >= 94) begin
         return cursor ? 12'h00f : 12'h000;
      end
      if (band == 3) begin
         return paletteRgb(r.colorTop);
      end
      if (band == 4) begin
         return paletteRgb(r.colorBottom);
      end
      lane = 2 - band;                  // Lowest band holds track0.
      if (cursor) begin
         return 12'h00f;
      end
      if (r.hCnt >= 640) begin
         return 12'hfff;
      end
      if (r.hCnt % 40 >= 38) begin
         return 12'h000;
      end
      step = r.hCnt / 40;
      word = (lane == 0) ? r.track0 : (lane == 1) ? r.track1 : r.track2;
      if (int'(r.trackChange) == lane && int'(r.trackSelect) == step) begin
         return 12'h0f0;
      end
      return word[step] ? 12'hf00 : 12'hfff;
   endfunction

   function automatic rowT randomRow();
      rowT r;
      r.hCnt = 10'($urandom_range(0, 1023));
      r.vCnt = 10'($urandom_range(0, 575));
      r.valid = ($urandom_range(0, 9) != 0);
      r.vgaIter = ($urandom_range(0, 3) == 0) ? r.hCnt : 10'($urandom_range(0, 1023));
      r.trackChange = 2'($urandom_range(0, 3));
      r.trackSelect = 4'($urandom_range(0, 15));
      if ($urandom_range(0, 3) == 0) begin
         r.trackSelect = 4'(r.hCnt / 40);  // Land on the edited step more often.
      end
      r.track0 = 16'($urandom);
      r.track1 = 16'($urandom);
      r.track2 = 16'($urandom);
      r.colorTop = 3'($urandom_range(0, 7));
      r.colorBottom = 3'($urandom_range(0, 7));
      r.rgb = modelPixel(r);
      return r;
   endfunction

   // ------------------------------------------------------------
   // Drive and check.
   // ------------------------------------------------------------
   task automatic driveInputs(input rowT r);
      hCnt = r.hCnt;
      vCnt = r.vCnt;
      valid = r.valid;
      vgaIter = r.vgaIter;
      trackChange = r.trackChange;
      trackSelect = r.trackSelect;
      track0 = r.track0;
      track1 = r.track1;
      track2 = r.track2;
      colorTop = r.colorTop;
      colorBottom = r.colorBottom;
   endtask

   task automatic checkOldest();
      logic [11:0] expected;
      logic [11:0] got;
      expected = expQ.pop_front();
      got = {vgaRed, vgaGreen, vgaBlue};
      assert (got === expected) else begin
         $display("ERROR rgb got %h expected %h", got, expected);
         $display("ERRORS FOUND");
         $fatal(1, "Pixel colour mismatch");
      end
   endtask

   // Output seen now belongs to the row driven two edges ago.
   task automatic applyRow(input rowT r);
      @(posedge clk);
      #1;
      checkOldest();
      driveInputs(r);
      expQ.push_back(r.rgb);
   endtask

   initial begin
      void'($urandom(45));
      rstN = 1'b0;
      // A coloured swatch pixel, so a missed reset would show.
      driveInputs('{10'd300, 10'd300, 1'b1, 10'd1023, 2'd3, 4'd0,
                    16'h0011, 16'h0030, 16'h8100, 3'd1, 3'd1, 12'h000});
      expQ.push_back(12'h000);
      expQ.push_back(12'h000);
      repeat (2) begin
         @(posedge clk);
         #1;
         checkOldest();
         expQ.push_back(12'h000);
      end
      rstN = 1'b1;
      valid = 1'b0;
      for (int i = 0; i < numRows; i++) begin
         applyRow(rows[i]);
      end
      for (int i = 0; i < numRandom; i++) begin
         applyRow(randomRow());
      end
      repeat (2) begin
         @(posedge clk);
         #1;
         checkOldest();
      end
      $display("NO ERRORS");
      $finish;
   end

   initial begin
      #((numRows + numRandom + 10) * clkPeriod);
      $display("Run timed out before all pixels were checked");
      $display("ERRORS FOUND");
      $fatal(1, "Watchdog expired");
   end

endmodule
